/* compile.f */
hw/cpu_types_pkg.sv
hw/control_unit.sv
hw/register_file.sv
hw/alu.sv
hw/pc.sv
hw/request_unit.sv
hw/datapath.sv
verification/datapath_tb.sv

/* Bender.yml */
package:
  name: datapath

sources:
  - hw/cpu_types_pkg.sv
  - hw/control_unit.sv
  - hw/register_file.sv
  - hw/alu.sv
  - hw/pc.sv
  - hw/request_unit.sv
  - hw/datapath.sv
  - target: test
    files:
      - verification/datapath_tb.sv

/* verification/datapath_tb.sv */
`timescale 1ns/100ps

module datapath_tb;

   localparam cpu_types_pkg::word_t PC_INIT = 32'h0000_0100;
   // cycles allowed between two stores, and the quiet window after halt
   localparam int STORE_TIMEOUT = 100;
   localparam int HALT_WINDOW   = 40;

   logic                 CLK;
   logic                 rst_n;
   logic                 ihit;
   logic                 dhit;
   cpu_types_pkg::word_t imemload;
   cpu_types_pkg::word_t dmemload;
   logic                 imemREN;
   logic                 dmemREN;
   logic                 dmemWEN;
   logic                 halt;
   cpu_types_pkg::word_t imemaddr;
   cpu_types_pkg::word_t dmemaddr;
   cpu_types_pkg::word_t dmemstore;

   // program image and expected (address, data) store sequence
   cpu_types_pkg::word_t prog [$];
   cpu_types_pkg::word_t exp_addr [$];
   cpu_types_pkg::word_t exp_data [$];
   // data memory of the cache model
   cpu_types_pkg::word_t dmem [64];
   // hit delay state
   cpu_types_pkg::word_t rng;
   int                   hit_wait;

   datapath #(.PC_INIT(PC_INIT)) UUT (
      .CLK(CLK), .rst_n(rst_n), .ihit(ihit), .dhit(dhit),
      .imemload(imemload), .dmemload(dmemload), .imemREN(imemREN),
      .dmemREN(dmemREN), .dmemWEN(dmemWEN), .halt(halt),
      .imemaddr(imemaddr), .dmemaddr(dmemaddr), .dmemstore(dmemstore)
   );

   // 8 ns period
   always #4 CLK = ~CLK;

   ////////////////////////////////////////////////////////////////////////////
   // instruction encoding and random delays
   ////////////////////////////////////////////////////////////////////////////

   function automatic cpu_types_pkg::word_t rtype_word(
      cpu_types_pkg::funct_t fn, cpu_types_pkg::regbits_t rs,
      cpu_types_pkg::regbits_t rt, cpu_types_pkg::regbits_t rd, logic [4:0] sh);
      return {cpu_types_pkg::OP_RTYPE, rs, rt, rd, sh, fn};
   endfunction

   function automatic cpu_types_pkg::word_t itype_word(
      cpu_types_pkg::opcode_t op, cpu_types_pkg::regbits_t rs,
      cpu_types_pkg::regbits_t rt, logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // target is a byte address in the same 256 MB region
   function automatic cpu_types_pkg::word_t jump_word(
      cpu_types_pkg::opcode_t op, cpu_types_pkg::word_t target);
      return {op, target[27:2]};
   endfunction

   function automatic cpu_types_pkg::word_t xorshift32(cpu_types_pkg::word_t x);
      cpu_types_pkg::word_t y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // outside the program the fetch returns halt
   function automatic cpu_types_pkg::word_t fetch_word(cpu_types_pkg::word_t addr);
      cpu_types_pkg::word_t idx;
      idx = (addr - PC_INIT) >> 2;
      if (addr < PC_INIT || idx >= prog.size()) begin
         return cpu_types_pkg::HALT_WORD;
      end
      return prog[idx];
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // cache model
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge CLK) begin
      ihit <= 1'b0;
      dhit <= 1'b0;
      if (!rst_n) begin
         hit_wait = -1;
      end else if (ihit || dhit) begin
         // answered at this edge, the request level drops now
         hit_wait = -1;
      end else if (dmemREN || dmemWEN || imemREN) begin
         if (hit_wait < 0) begin
            rng = xorshift32(rng);
            hit_wait = rng[1:0];
         end
         if (hit_wait == 0) begin
            hit_wait = -1;
            // data side first
            if (dmemREN || dmemWEN) begin
               dhit     <= 1'b1;
               dmemload <= dmem[dmemaddr[7:2]];
               if (dmemWEN) begin
                  dmem[dmemaddr[7:2]] = dmemstore;
               end
            end else begin
               ihit     <= 1'b1;
               imemload <= fetch_word(imemaddr);
            end
         end else begin
            hit_wait = hit_wait - 1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // checks and waits
   ////////////////////////////////////////////////////////////////////////////

   task end_with_failure();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task check_word(string name, cpu_types_pkg::word_t got, cpu_types_pkg::word_t exp);
      if (got !== exp) begin
         $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
         end_with_failure();
      end
   endtask

   task check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
         end_with_failure();
      end
   endtask

   task report_timeout(string what);
      $display("Timeout while waiting for %s", what);
      end_with_failure();
   endtask

   task wait_fetch_start();
      int n;
      n = 0;
      @(negedge CLK);
      while (!imemREN) begin
         n++;
         if (n > 8) report_timeout("the first fetch request after reset");
         @(negedge CLK);
      end
   endtask

   // one committed store is a data write in its dhit cycle
   task wait_store();
      int n;
      n = 0;
      @(negedge CLK);
      while (!(dmemWEN && dhit)) begin
         n++;
         if (n > STORE_TIMEOUT) report_timeout("the next committed store");
         @(negedge CLK);
      end
   endtask

   task wait_halt();
      int n;
      n = 0;
      @(negedge CLK);
      while (!halt) begin
         if (dmemWEN && dhit) begin
            $display("Unexpected store to 0x%h after the last expected one", dmemaddr);
            end_with_failure();
         end
         n++;
         if (n > STORE_TIMEOUT) report_timeout("halt to go high");
         @(negedge CLK);
      end
   endtask

   // data requests never overlap and never run beside a fetch
   always @(negedge CLK) begin
      if (rst_n) begin
         check_bit("dmemREN & dmemWEN", dmemREN & dmemWEN, 1'b0);
         if (dmemREN || dmemWEN) begin
            check_bit("imemREN", imemREN, 1'b0);
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // program and expected stores
   ////////////////////////////////////////////////////////////////////////////

   task load_program();
      // add and subtract with a negative operand
      prog.push_back(itype_word(cpu_types_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h0007));
      prog.push_back(itype_word(cpu_types_pkg::OP_ADDIU, 5'd0, 5'd2, 16'hfffd));
      prog.push_back(rtype_word(cpu_types_pkg::FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd3, 16'h0000));
      prog.push_back(rtype_word(cpu_types_pkg::FN_SUBU, 5'd1, 5'd2, 5'd4, 5'd0));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd4, 16'h0004));
      // lui then zero-extended logic immediates
      prog.push_back(itype_word(cpu_types_pkg::OP_LUI, 5'd0, 5'd5, 16'hf0f0));
      prog.push_back(itype_word(cpu_types_pkg::OP_ORI, 5'd5, 5'd5, 16'h8421));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd5, 16'h0008));
      prog.push_back(itype_word(cpu_types_pkg::OP_ANDI, 5'd5, 5'd6, 16'hff0f));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd6, 16'h000c));
      prog.push_back(itype_word(cpu_types_pkg::OP_XORI, 5'd2, 5'd7, 16'h8000));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd7, 16'h0010));
      // register logic ops
      prog.push_back(rtype_word(cpu_types_pkg::FN_AND, 5'd5, 5'd7, 5'd8, 5'd0));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd8, 16'h0014));
      prog.push_back(rtype_word(cpu_types_pkg::FN_OR, 5'd1, 5'd5, 5'd9, 5'd0));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd9, 16'h0018));
      prog.push_back(rtype_word(cpu_types_pkg::FN_XOR, 5'd5, 5'd7, 5'd10, 5'd0));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd10, 16'h001c));
      prog.push_back(rtype_word(cpu_types_pkg::FN_NOR, 5'd1, 5'd4, 5'd11, 5'd0));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd11, 16'h0020));
      // -3 against 7, signed then unsigned
      prog.push_back(rtype_word(cpu_types_pkg::FN_SLT, 5'd2, 5'd1, 5'd12, 5'd0));
      prog.push_back(rtype_word(cpu_types_pkg::FN_SLTU, 5'd2, 5'd1, 5'd13, 5'd0));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd12, 16'h0024));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd13, 16'h0028));
      // shifts act on rt
      prog.push_back(rtype_word(cpu_types_pkg::FN_SLL, 5'd0, 5'd5, 5'd14, 5'd4));
      prog.push_back(rtype_word(cpu_types_pkg::FN_SRL, 5'd0, 5'd5, 5'd15, 5'd8));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd14, 16'h002c));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd15, 16'h0030));
      prog.push_back(itype_word(cpu_types_pkg::OP_SLTI, 5'd2, 5'd16, 16'hfffe));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd16, 16'h0034));
      // write to $0 is dropped
      prog.push_back(itype_word(cpu_types_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h0005));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd0, 16'h0038));
      // load back and copy, second pair uses a base register
      prog.push_back(itype_word(cpu_types_pkg::OP_LW, 5'd0, 5'd18, 16'h0008));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd18, 16'h003c));
      prog.push_back(itype_word(cpu_types_pkg::OP_LW, 5'd3, 5'd19, 16'h0010));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd3, 5'd19, 16'h003c));
      // branches, poison stores go to 0x7c
      prog.push_back(itype_word(cpu_types_pkg::OP_BEQ, 5'd1, 5'd2, 16'h0001));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd1, 16'h0044));
      prog.push_back(itype_word(cpu_types_pkg::OP_BEQ, 5'd3, 5'd3, 16'h0001));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd2, 16'h007c));
      prog.push_back(itype_word(cpu_types_pkg::OP_BNE, 5'd1, 5'd1, 16'h0001));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd4, 16'h0048));
      prog.push_back(itype_word(cpu_types_pkg::OP_BNE, 5'd1, 5'd2, 16'h0001));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd2, 16'h007c));
      // j to 0x1bc, jal to 0x1cc, jr back to 0x1c0
      prog.push_back(jump_word(cpu_types_pkg::OP_J, 32'h0000_01bc));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd2, 16'h007c));
      prog.push_back(jump_word(cpu_types_pkg::OP_JAL, 32'h0000_01cc));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd31, 16'h004c));
      prog.push_back(cpu_types_pkg::HALT_WORD);
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd2, 16'h007c));
      prog.push_back(itype_word(cpu_types_pkg::OP_SW, 5'd0, 5'd1, 16'h0050));
      prog.push_back(rtype_word(cpu_types_pkg::FN_JR, 5'd31, 5'd0, 5'd0, 5'd0));
   endtask

   task expect_store(cpu_types_pkg::word_t addr, cpu_types_pkg::word_t data);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endtask

   task load_expected();
      expect_store(32'h00, 32'h0000_0004);
      expect_store(32'h04, 32'h0000_000a);
      expect_store(32'h08, 32'hf0f0_8421);
      expect_store(32'h0c, 32'h0000_8401);
      expect_store(32'h10, 32'hffff_7ffd);
      expect_store(32'h14, 32'hf0f0_0421);
      expect_store(32'h18, 32'hf0f0_8427);
      expect_store(32'h1c, 32'h0f0f_fbdc);
      expect_store(32'h20, 32'hffff_fff0);
      expect_store(32'h24, 32'h0000_0001);
      expect_store(32'h28, 32'h0000_0000);
      expect_store(32'h2c, 32'h0f08_4210);
      expect_store(32'h30, 32'h00f0_f084);
      expect_store(32'h34, 32'h0000_0001);
      expect_store(32'h38, 32'h0000_0000);
      expect_store(32'h3c, 32'hf0f0_8421);
      expect_store(32'h40, 32'hf0f0_0421);
      expect_store(32'h44, 32'h0000_0007);
      expect_store(32'h48, 32'h0000_000a);
      // subroutine store, then the link value after jr
      expect_store(32'h50, 32'h0000_0007);
      expect_store(32'h4c, 32'h0000_01c0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int i;
      CLK      = 1'b0;
      rst_n    = 1'b0;
      ihit     = 1'b0;
      dhit     = 1'b0;
      imemload = '0;
      dmemload = '0;
      rng      = 32'd56628;
      hit_wait = -1;
      // fill tied to each word's byte address
      for (i = 0; i < 64; i++) begin
         dmem[i] = 32'h5a5a_0000 ^ (i << 2);
      end
      load_program();
      load_expected();

      // outputs quiet through reset
      for (i = 0; i < 16; i++) begin
         @(negedge CLK);
         check_bit("imemREN", imemREN, 1'b0);
         check_bit("dmemREN", dmemREN, 1'b0);
         check_bit("dmemWEN", dmemWEN, 1'b0);
         check_bit("halt", halt, 1'b0);
      end
      @(posedge CLK);
      rst_n <= 1'b1;

      wait_fetch_start();
      check_word("imemaddr", imemaddr, PC_INIT);

      // stores in program order
      for (i = 0; i < exp_addr.size(); i++) begin
         wait_store();
         check_word("dmemaddr", dmemaddr, exp_addr[i]);
         check_word("dmemstore", dmemstore, exp_data[i]);
      end

      // halted core stays silent
      wait_halt();
      for (i = 0; i < HALT_WINDOW; i++) begin
         @(negedge CLK);
         check_bit("halt", halt, 1'b1);
         check_bit("imemREN", imemREN, 1'b0);
         check_bit("dmemREN", dmemREN, 1'b0);
         check_bit("dmemWEN", dmemWEN, 1'b0);
      end
      $display("Simulation passed");
      $finish;
   end

endmodule

/* hw/datapath.sv */
`timescale 1ns/100ps

module datapath #(
   parameter cpu_types_pkg::word_t PC_INIT = '0
) (
   input  logic                 CLK,
   input  logic                 rst_n,
   input  logic                 ihit,
   input  logic                 dhit,
   input  cpu_types_pkg::word_t imemload,
   input  cpu_types_pkg::word_t dmemload,
   output logic                 imemREN,
   output logic                 dmemREN,
   output logic                 dmemWEN,
   output logic                 halt,
   output cpu_types_pkg::word_t imemaddr,
   output cpu_types_pkg::word_t dmemaddr,
   output cpu_types_pkg::word_t dmemstore
);

   // decode outputs
   cpu_types_pkg::regbits_t rs;
   cpu_types_pkg::regbits_t rt;
   cpu_types_pkg::regbits_t rd;
   logic [15:0]             imm16;
   logic [4:0]              shamt;
   cpu_types_pkg::aluop_t   alu_op;
   logic [1:0]              alusrc;
   logic [1:0]              regdst;
   logic [1:0]              memtoreg;
   logic [1:0]              pcsrc;
   logic                    extop;
   logic                    regwr;
   logic                    dread;
   logic                    dwrite;
   logic                    halt_op;
   // register file and alu
   cpu_types_pkg::regbits_t wsel;
   cpu_types_pkg::word_t    wdat;
   cpu_types_pkg::word_t    rdat1;
   cpu_types_pkg::word_t    rdat2;
   cpu_types_pkg::word_t    op2;
   cpu_types_pkg::word_t    alu_res;
   logic                    flag_z;
   // commit strobes
   logic                    pc_en;
   logic                    reg_wen;

   ////////////////////////////////////////////////////////////////////////////
   // blocks
   ////////////////////////////////////////////////////////////////////////////

   control_unit u_cu (
      .instr(imemload), .zero(flag_z), .rs(rs), .rt(rt), .rd(rd),
      .imm16(imm16), .shamt(shamt), .alu_op(alu_op), .alusrc(alusrc),
      .regdst(regdst), .memtoreg(memtoreg), .pcsrc(pcsrc), .extop(extop),
      .regwr(regwr), .dread(dread), .dwrite(dwrite), .halt_op(halt_op)
   );

   register_file u_rf (
      .CLK(CLK), .rst_n(rst_n), .wen(reg_wen), .wsel(wsel),
      .rsel1(rs), .rsel2(rt), .wdat(wdat), .rdat1(rdat1), .rdat2(rdat2)
   );

   // n and v flags unused by this isa subset
   alu u_alu (
      .op1(rdat1), .op2(op2), .alu_op(alu_op), .shamt(shamt), .res(alu_res),
      .flag_n(), .flag_v(), .flag_z(flag_z)
   );

   // jr target comes through the alu
   pc #(.PC_INIT(PC_INIT)) u_pc (
      .CLK(CLK), .rst_n(rst_n), .pc_en(pc_en), .halt_op(halt_op),
      .pcsrc(pcsrc), .imm16(imm16), .imm26(imemload[25:0]),
      .regval(alu_res), .imemaddr(imemaddr), .halt(halt)
   );

   request_unit u_rq (
      .CLK(CLK), .rst_n(rst_n), .ihit(ihit), .dhit(dhit), .dread(dread),
      .dwrite(dwrite), .regwr(regwr), .halt(halt), .imemREN(imemREN),
      .dmemREN(dmemREN), .dmemWEN(dmemWEN), .pc_en(pc_en), .reg_wen(reg_wen)
   );

   ////////////////////////////////////////////////////////////////////////////
   // glue
   ////////////////////////////////////////////////////////////////////////////

   // operand b with sign, zero or upper extension
   always_comb begin
      case (alusrc)
         cpu_types_pkg::SRC_IMM:
            op2 = extop ? {{16{imm16[15]}}, imm16} : {16'b0, imm16};
         cpu_types_pkg::SRC_UPPER: op2 = {imm16, 16'b0};
         default:                  op2 = rdat2;
      endcase
   end

   // write-back data, link is pc+4
   always_comb begin
      case (memtoreg)
         cpu_types_pkg::MEM_LOAD: wdat = dmemload;
         cpu_types_pkg::MEM_LINK: wdat = imemaddr + 32'd4;
         default:                 wdat = alu_res;
      endcase
   end

   // write destination
   always_comb begin
      case (regdst)
         cpu_types_pkg::DST_RT:  wsel = rt;
         cpu_types_pkg::DST_R31: wsel = 5'd31;
         default:                wsel = rd;
      endcase
   end

   // data side
   assign dmemaddr  = alu_res;
   assign dmemstore = rdat2;

endmodule

/* hw/request_unit.sv */
`timescale 1ns/100ps

module request_unit (
   input  logic CLK,
   input  logic rst_n,
   input  logic ihit,
   input  logic dhit,
   input  logic dread,
   input  logic dwrite,
   input  logic regwr,
   input  logic halt,
   output logic imemREN,
   output logic dmemREN,
   output logic dmemWEN,
   output logic pc_en,
   output logic reg_wen
);

   typedef enum logic {
      FETCH,
      DATA_WAIT
   } state_t;

   state_t state;
   // low only through the reset cycles
   logic   started;

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         state   <= FETCH;
         started <= 1'b0;
         dmemREN <= 1'b0;
         dmemWEN <= 1'b0;
      end else begin
         started <= 1'b1;
         case (state)
            FETCH: begin
               // memory op fetched, raise its request next cycle
               if (ihit && (dread || dwrite)) begin
                  state   <= DATA_WAIT;
                  dmemREN <= dread;
                  dmemWEN <= dwrite;
               end
            end
            default: begin
               // hold request until the data hit
               if (dhit) begin
                  state   <= FETCH;
                  dmemREN <= 1'b0;
                  dmemWEN <= 1'b0;
               end
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // fetch request and commit strobes
   ////////////////////////////////////////////////////////////////////////////

   assign imemREN = started && (state == FETCH) && !halt;

   // non-memory op commits at ihit, memory op at dhit
   assign pc_en = (state == FETCH) ? (imemREN && ihit && !dread && !dwrite)
                                   : dhit;
   assign reg_wen = pc_en && regwr;

   a_no_rw_overlap : assert property (
      @(posedge CLK) disable iff (!rst_n)
      !(dmemREN && dmemWEN)
   );

   // no fetch while a data request is outstanding
   a_no_fetch_in_data : assert property (
      @(posedge CLK) disable iff (!rst_n)
      (dmemREN || dmemWEN) |-> !imemREN
   );

endmodule

/* hw/pc.sv */
`timescale 1ns/100ps

module pc #(
   parameter cpu_types_pkg::word_t PC_INIT = '0
) (
   input  logic                 CLK,
   input  logic                 rst_n,
   input  logic                 pc_en,
   input  logic                 halt_op,
   input  logic [1:0]           pcsrc,
   input  logic [15:0]          imm16,
   input  logic [25:0]          imm26,
   input  cpu_types_pkg::word_t regval,
   output cpu_types_pkg::word_t imemaddr,
   output logic                 halt
);

   cpu_types_pkg::word_t pc_plus4;
   cpu_types_pkg::word_t next_pc;

   assign pc_plus4 = imemaddr + 32'd4;

   // next address select
   always_comb begin
      case (pcsrc)
         cpu_types_pkg::PC_BRANCH:
            next_pc = pc_plus4 + {{14{imm16[15]}}, imm16, 2'b00};
         cpu_types_pkg::PC_JUMP: next_pc = {pc_plus4[31:28], imm26, 2'b00};
         cpu_types_pkg::PC_REG:  next_pc = regval;
         default:                next_pc = pc_plus4;
      endcase
   end

   // pc frozen once halted, halt itself is sticky
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         imemaddr <= PC_INIT;
         halt     <= 1'b0;
      end else if (pc_en && !halt) begin
         if (halt_op) begin
            halt <= 1'b1;
         end else begin
            imemaddr <= next_pc;
         end
      end
   end

   a_pc_aligned : assert property (
      @(posedge CLK) disable iff (!rst_n)
      imemaddr[1:0] == 2'b00
   );

endmodule

/* hw/alu.sv */
`timescale 1ns/100ps

module alu (
   input  cpu_types_pkg::word_t  op1,
   input  cpu_types_pkg::word_t  op2,
   input  cpu_types_pkg::aluop_t alu_op,
   input  logic [4:0]            shamt,
   output cpu_types_pkg::word_t  res,
   output logic                  flag_n,
   output logic                  flag_v,
   output logic                  flag_z
);

   always_comb begin
      res    = '0;
      flag_v = 1'b0;
      case (alu_op)
         cpu_types_pkg::ALU_ADD: begin
            res = op1 + op2;
            // same-sign inputs, result sign flipped
            flag_v = (op1[31] == op2[31]) && (res[31] != op1[31]);
         end
         cpu_types_pkg::ALU_SUB: begin
            res = op1 - op2;
            // opposite-sign inputs, result sign differs from op1
            flag_v = (op1[31] != op2[31]) && (res[31] != op1[31]);
         end
         cpu_types_pkg::ALU_AND: res = op1 & op2;
         cpu_types_pkg::ALU_OR:  res = op1 | op2;
         cpu_types_pkg::ALU_XOR: res = op1 ^ op2;
         cpu_types_pkg::ALU_NOR: res = ~(op1 | op2);
         // signed compare
         cpu_types_pkg::ALU_SLT: res = {31'b0, $signed(op1) < $signed(op2)};
         // unsigned compare
         cpu_types_pkg::ALU_SLTU: res = {31'b0, op1 < op2};
         // shifts act on rt, i.e. op2
         cpu_types_pkg::ALU_SLL: res = op2 << shamt;
         cpu_types_pkg::ALU_SRL: res = op2 >> shamt;
         default: res = '0;
      endcase
   end

   // result flags
   assign flag_n = res[31];
   assign flag_z = (res == '0);

endmodule

/* hw/register_file.sv */
`timescale 1ns/100ps

module register_file (
   input  logic                    CLK,
   input  logic                    rst_n,
   input  logic                    wen,
   input  cpu_types_pkg::regbits_t wsel,
   input  cpu_types_pkg::regbits_t rsel1,
   input  cpu_types_pkg::regbits_t rsel2,
   input  cpu_types_pkg::word_t    wdat,
   output cpu_types_pkg::word_t    rdat1,
   output cpu_types_pkg::word_t    rdat2
);

   // 32 general purpose registers
   cpu_types_pkg::word_t regs [32];

   // write port, $0 never written
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         regs <= '{default: '0};
      end else if (wen && (wsel != '0)) begin
         regs[wsel] <= wdat;
      end
   end

   // asynchronous read ports
   assign rdat1 = regs[rsel1];
   assign rdat2 = regs[rsel2];

   // a read of $0 returns zero on both ports
   a_reg0_read : assert property (
      @(posedge CLK) disable iff (!rst_n)
      (rsel1 == '0 |-> rdat1 == '0) and (rsel2 == '0 |-> rdat2 == '0)
   );

endmodule

/* hw/control_unit.sv */
`timescale 1ns/100ps

module control_unit (
   input  cpu_types_pkg::word_t    instr,
   input  logic                    zero,
   output cpu_types_pkg::regbits_t rs,
   output cpu_types_pkg::regbits_t rt,
   output cpu_types_pkg::regbits_t rd,
   output logic [15:0]             imm16,
   output logic [4:0]              shamt,
   output cpu_types_pkg::aluop_t   alu_op,
   output logic [1:0]              alusrc,
   output logic [1:0]              regdst,
   output logic [1:0]              memtoreg,
   output logic [1:0]              pcsrc,
   output logic                    extop,
   output logic                    regwr,
   output logic                    dread,
   output logic                    dwrite,
   output logic                    halt_op
);

   cpu_types_pkg::opcode_t opcode;
   cpu_types_pkg::funct_t  funct;

   // field slicing
   assign opcode = instr[31:26];
   assign funct  = instr[5:0];
   assign rs     = instr[25:21];
   assign rt     = instr[20:16];
   assign rd     = instr[15:11];
   assign shamt  = instr[10:6];
   assign imm16  = instr[15:0];

   // halt is the full all-ones word, not just its opcode
   assign halt_op = (instr == cpu_types_pkg::HALT_WORD);

   always_comb begin
      // defaults behave as a nop
      alu_op   = cpu_types_pkg::ALU_ADD;
      alusrc   = cpu_types_pkg::SRC_REG;
      regdst   = cpu_types_pkg::DST_RD;
      memtoreg = cpu_types_pkg::MEM_ALU;
      pcsrc    = cpu_types_pkg::PC_NEXT;
      extop    = 1'b0;
      regwr    = 1'b0;
      dread    = 1'b0;
      dwrite   = 1'b0;
      case (opcode)
         cpu_types_pkg::OP_RTYPE: begin
            regwr = 1'b1;
            case (funct)
               cpu_types_pkg::FN_ADDU: alu_op = cpu_types_pkg::ALU_ADD;
               cpu_types_pkg::FN_SUBU: alu_op = cpu_types_pkg::ALU_SUB;
               cpu_types_pkg::FN_AND:  alu_op = cpu_types_pkg::ALU_AND;
               cpu_types_pkg::FN_OR:   alu_op = cpu_types_pkg::ALU_OR;
               cpu_types_pkg::FN_XOR:  alu_op = cpu_types_pkg::ALU_XOR;
               cpu_types_pkg::FN_NOR:  alu_op = cpu_types_pkg::ALU_NOR;
               cpu_types_pkg::FN_SLT:  alu_op = cpu_types_pkg::ALU_SLT;
               cpu_types_pkg::FN_SLTU: alu_op = cpu_types_pkg::ALU_SLTU;
               cpu_types_pkg::FN_SLL:  alu_op = cpu_types_pkg::ALU_SLL;
               cpu_types_pkg::FN_SRL:  alu_op = cpu_types_pkg::ALU_SRL;
               cpu_types_pkg::FN_JR: begin
                  // rt field is zero in jr, so alu passes rs through
                  regwr = 1'b0;
                  pcsrc = cpu_types_pkg::PC_REG;
               end
               default: regwr = 1'b0;
            endcase
         end
         // immediates, destination is rt
         cpu_types_pkg::OP_ADDIU, cpu_types_pkg::OP_SLTI,
         cpu_types_pkg::OP_ANDI, cpu_types_pkg::OP_ORI,
         cpu_types_pkg::OP_XORI, cpu_types_pkg::OP_LUI: begin
            regwr  = 1'b1;
            regdst = cpu_types_pkg::DST_RT;
            alusrc = cpu_types_pkg::SRC_IMM;
            case (opcode)
               cpu_types_pkg::OP_ADDIU: extop = 1'b1;
               cpu_types_pkg::OP_SLTI: begin
                  extop  = 1'b1;
                  alu_op = cpu_types_pkg::ALU_SLT;
               end
               cpu_types_pkg::OP_ANDI: alu_op = cpu_types_pkg::ALU_AND;
               cpu_types_pkg::OP_ORI:  alu_op = cpu_types_pkg::ALU_OR;
               cpu_types_pkg::OP_XORI: alu_op = cpu_types_pkg::ALU_XOR;
               default: begin
                  // lui, rs is $0 so or gives imm16 << 16
                  alu_op = cpu_types_pkg::ALU_OR;
                  alusrc = cpu_types_pkg::SRC_UPPER;
               end
            endcase
         end
         cpu_types_pkg::OP_LW: begin
            regwr    = 1'b1;
            dread    = 1'b1;
            extop    = 1'b1;
            alusrc   = cpu_types_pkg::SRC_IMM;
            regdst   = cpu_types_pkg::DST_RT;
            memtoreg = cpu_types_pkg::MEM_LOAD;
         end
         cpu_types_pkg::OP_SW: begin
            dwrite = 1'b1;
            extop  = 1'b1;
            alusrc = cpu_types_pkg::SRC_IMM;
         end
         // branches compare rs - rt, taken resolved here
         cpu_types_pkg::OP_BEQ: begin
            alu_op = cpu_types_pkg::ALU_SUB;
            pcsrc  = zero ? cpu_types_pkg::PC_BRANCH : cpu_types_pkg::PC_NEXT;
         end
         cpu_types_pkg::OP_BNE: begin
            alu_op = cpu_types_pkg::ALU_SUB;
            pcsrc  = zero ? cpu_types_pkg::PC_NEXT : cpu_types_pkg::PC_BRANCH;
         end
         cpu_types_pkg::OP_J: pcsrc = cpu_types_pkg::PC_JUMP;
         cpu_types_pkg::OP_JAL: begin
            // link pc+4 into $31
            pcsrc    = cpu_types_pkg::PC_JUMP;
            regwr    = 1'b1;
            regdst   = cpu_types_pkg::DST_R31;
            memtoreg = cpu_types_pkg::MEM_LINK;
         end
         // halt and unknown opcodes write nothing
         default: regwr = 1'b0;
      endcase
   end

endmodule

/* hw/cpu_types_pkg.sv */
package cpu_types_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // basic widths
   ////////////////////////////////////////////////////////////////////////////

   // data, address and instruction word
   typedef logic [31:0] word_t;
   // register index
   typedef logic [4:0] regbits_t;
   // instruction fields
   typedef logic [5:0] opcode_t;
   typedef logic [5:0] funct_t;
   // alu operation select
   typedef logic [3:0] aluop_t;

   ////////////////////////////////////////////////////////////////////////////
   // instruction encodings
   ////////////////////////////////////////////////////////////////////////////

   // opcodes, instr[31:26]
   localparam opcode_t OP_RTYPE = 6'h00;
   localparam opcode_t OP_J     = 6'h02;
   localparam opcode_t OP_JAL   = 6'h03;
   localparam opcode_t OP_BEQ   = 6'h04;
   localparam opcode_t OP_BNE   = 6'h05;
   localparam opcode_t OP_ADDIU = 6'h09;
   localparam opcode_t OP_SLTI  = 6'h0a;
   localparam opcode_t OP_ANDI  = 6'h0c;
   localparam opcode_t OP_ORI   = 6'h0d;
   localparam opcode_t OP_XORI  = 6'h0e;
   localparam opcode_t OP_LUI   = 6'h0f;
   localparam opcode_t OP_LW    = 6'h23;
   localparam opcode_t OP_SW    = 6'h2b;

   // r-type function codes, instr[5:0]
   localparam funct_t FN_SLL  = 6'h00;
   localparam funct_t FN_SRL  = 6'h02;
   localparam funct_t FN_JR   = 6'h08;
   localparam funct_t FN_ADDU = 6'h21;
   localparam funct_t FN_SUBU = 6'h23;
   localparam funct_t FN_AND  = 6'h24;
   localparam funct_t FN_OR   = 6'h25;
   localparam funct_t FN_XOR  = 6'h26;
   localparam funct_t FN_NOR  = 6'h27;
   localparam funct_t FN_SLT  = 6'h2a;
   localparam funct_t FN_SLTU = 6'h2b;

   // whole-word halt
   localparam word_t HALT_WORD = 32'hffff_ffff;

   ////////////////////////////////////////////////////////////////////////////
   // alu operations and mux selects
   ////////////////////////////////////////////////////////////////////////////

   localparam aluop_t ALU_ADD  = 4'd0;
   localparam aluop_t ALU_SUB  = 4'd1;
   localparam aluop_t ALU_AND  = 4'd2;
   localparam aluop_t ALU_OR   = 4'd3;
   localparam aluop_t ALU_XOR  = 4'd4;
   localparam aluop_t ALU_NOR  = 4'd5;
   localparam aluop_t ALU_SLT  = 4'd6;
   localparam aluop_t ALU_SLTU = 4'd7;
   localparam aluop_t ALU_SLL  = 4'd8;
   localparam aluop_t ALU_SRL  = 4'd9;

   // write-back source
   localparam logic [1:0] MEM_ALU  = 2'd0;
   localparam logic [1:0] MEM_LOAD = 2'd1;
   localparam logic [1:0] MEM_LINK = 2'd2;
   // write destination
   localparam logic [1:0] DST_RD  = 2'd0;
   localparam logic [1:0] DST_RT  = 2'd1;
   localparam logic [1:0] DST_R31 = 2'd2;
   // alu operand b
   localparam logic [1:0] SRC_REG   = 2'd0;
   localparam logic [1:0] SRC_IMM   = 2'd1;
   localparam logic [1:0] SRC_UPPER = 2'd2;
   // next pc
   localparam logic [1:0] PC_NEXT   = 2'd0;
   localparam logic [1:0] PC_BRANCH = 2'd1;
   localparam logic [1:0] PC_JUMP   = 2'd2;
   localparam logic [1:0] PC_REG    = 2'd3;

endpackage
